// ==== rv_defs.svh ====
`ifndef RV_DEFS_SVH
`define RV_DEFS_SVH

// datapath and register file sizing
`define RV_XLEN       32
`define RV_NUM_REGS   32
`define RV_REG_ADDR_W 5
`define RV_OPCODE_W   7
`define RV_ALU_OP_W   4

// major opcodes handled by the core
`define RV_OP_LUI    7'b0110111
`define RV_OP_AUIPC  7'b0010111
`define RV_OP_JAL    7'b1101111
`define RV_OP_JALR   7'b1100111
`define RV_OP_BRANCH 7'b1100011
`define RV_OP_IMM    7'b0010011
`define RV_OP_REG    7'b0110011
`define RV_OP_SYSTEM 7'b1110011

// alu codes mirror {insn[30], funct3} of the R-type encoding
`define RV_ALU_ADD  4'b0000
`define RV_ALU_SUB  4'b1000
`define RV_ALU_SLL  4'b0001
`define RV_ALU_SLT  4'b0010
`define RV_ALU_SLTU 4'b0011
`define RV_ALU_XOR  4'b0100
`define RV_ALU_SRL  4'b0101
`define RV_ALU_SRA  4'b1101
`define RV_ALU_OR   4'b0110
`define RV_ALU_AND  4'b0111

// branch conditions
`define RV_F3_BEQ  3'b000
`define RV_F3_BNE  3'b001
`define RV_F3_BLT  3'b100
`define RV_F3_BGE  3'b101
`define RV_F3_BLTU 3'b110
`define RV_F3_BGEU 3'b111

`endif

// ==== rv_pkg.sv ====
`default_nettype none

`include "rv_defs.svh"

package rv_pkg;

  // data word, also used for addresses
  typedef logic [`RV_XLEN-1:0] word_t;

  // raw instruction word from the instruction memory
  typedef logic [`RV_XLEN-1:0] insn_t;

  typedef logic [`RV_REG_ADDR_W-1:0] reg_addr_t; // x0..x31

  typedef logic [`RV_ALU_OP_W-1:0] alu_op_t;

  // branch condition selector
  typedef logic [2:0] funct3_t;

  // fetch sequencing, one instruction in flight
  typedef enum logic [1:0] {
    FETCH_REQ,     // req high, waiting for ack
    FETCH_RELEASE, // req low, waiting for ack to drop
    EXECUTE,       // single execute and retire cycle
    HALTED         // parked after ecall
  } fetch_state_t;

endpackage

`default_nettype wire

// ==== rv_decode_if.sv ====
`default_nettype none

// decoded fields from rv_decoder to rv_execute and the register file
interface rv_decode_if import rv_pkg::*; ();

  reg_addr_t rs1;
  reg_addr_t rs2;
  reg_addr_t rd;
  word_t     imm;       // already sign extended / shifted
  alu_op_t   alu_op;
  funct3_t   funct3;
  logic      use_imm;   // alu operand b from imm instead of rs2
  logic      rf_we;     // instruction class writes rd
  logic      is_branch;
  logic      is_jal;
  logic      is_jalr;
  logic      is_lui;
  logic      is_auipc;
  logic      is_ecall;

  modport decoder (
    output rs1, rs2, rd, imm, alu_op, funct3, use_imm, rf_we,
    output is_branch, is_jal, is_jalr, is_lui, is_auipc, is_ecall
  );

  modport execute (
    input rs1, rs2, rd, imm, alu_op, funct3, use_imm, rf_we,
    input is_branch, is_jal, is_jalr, is_lui, is_auipc, is_ecall
  );

endinterface

`default_nettype wire

// ==== rv_decoder.sv ====
`default_nettype none

`include "rv_defs.svh"

module rv_decoder import rv_pkg::*; (
  input  insn_t               insn,
  rv_decode_if.decoder        dec
);

  logic [`RV_OPCODE_W-1:0] opcode;
  funct3_t                 funct3;
  logic                    alt;     // funct7 bit 5, selects sub / sra
  logic                    is_op_imm;
  logic                    is_op_reg;
  word_t                   imm_i;
  word_t                   imm_b;
  word_t                   imm_j;
  word_t                   imm_u;

  assign opcode = insn[6:0];
  assign funct3 = insn[14:12];
  assign alt    = insn[30];

  assign dec.rs1    = insn[19:15];
  assign dec.rs2    = insn[24:20];
  assign dec.rd     = insn[11:7];
  assign dec.funct3 = funct3;

  // immediate formats
  assign imm_i = {{20{insn[31]}}, insn[31:20]};
  assign imm_b = {{20{insn[31]}}, insn[7], insn[30:25], insn[11:8], 1'b0};
  assign imm_j = {{12{insn[31]}}, insn[19:12], insn[20], insn[30:21], 1'b0};
  assign imm_u = {insn[31:12], 12'b0};

  // instruction classes
  assign is_op_imm     = (opcode == `RV_OP_IMM);
  assign is_op_reg     = (opcode == `RV_OP_REG);
  assign dec.is_lui    = (opcode == `RV_OP_LUI);
  assign dec.is_auipc  = (opcode == `RV_OP_AUIPC);
  assign dec.is_jal    = (opcode == `RV_OP_JAL);
  assign dec.is_jalr   = (opcode == `RV_OP_JALR);
  assign dec.is_branch = (opcode == `RV_OP_BRANCH);
  // only the plain ecall encoding halts, other system ops fall through as no-ops
  assign dec.is_ecall  = (opcode == `RV_OP_SYSTEM) && (insn[31:7] == '0);

  assign dec.use_imm = is_op_imm;

  // write-back classes; branches, ecall and unknown opcodes leave rd alone
  assign dec.rf_we = is_op_imm | is_op_reg | dec.is_lui | dec.is_auipc |
                     dec.is_jal | dec.is_jalr;

  always_comb begin
    case (opcode)
      `RV_OP_LUI,
      `RV_OP_AUIPC:  dec.imm = imm_u;
      `RV_OP_JAL:    dec.imm = imm_j;
      `RV_OP_BRANCH: dec.imm = imm_b;
      default:       dec.imm = imm_i; // op-imm and jalr
    endcase
  end

  // insn[30] is part of the immediate for addi, so sub only exists for op-reg
  always_comb begin
    case (funct3)
      3'b000: begin
        if (is_op_reg && alt) begin
          dec.alu_op = `RV_ALU_SUB;
        end else begin
          dec.alu_op = `RV_ALU_ADD;
        end
      end
      3'b001: dec.alu_op = `RV_ALU_SLL;
      3'b010: dec.alu_op = `RV_ALU_SLT;
      3'b011: dec.alu_op = `RV_ALU_SLTU;
      3'b100: dec.alu_op = `RV_ALU_XOR;
      3'b101: begin
        if (alt) begin
          dec.alu_op = `RV_ALU_SRA;  // srai keeps bit 30 in its imm field
        end else begin
          dec.alu_op = `RV_ALU_SRL;
        end
      end
      3'b110: dec.alu_op = `RV_ALU_OR;
      default: dec.alu_op = `RV_ALU_AND;
    endcase
  end

endmodule

`default_nettype wire

// ==== rv_regfile.sv ====
`default_nettype none

`include "rv_defs.svh"

module rv_regfile import rv_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  logic      we,
  input  reg_addr_t rd,
  input  word_t     rd_data,
  input  reg_addr_t rs1,
  input  reg_addr_t rs2,
  output word_t     rs1_data,
  output word_t     rs2_data
);

  // x0 has no storage
  word_t regs [1:`RV_NUM_REGS-1];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 1; i < `RV_NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we && (rd != '0)) begin
      regs[rd] <= rd_data;
    end
  end

  // combinational reads with x0 forced to zero
  assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

  // a register written on the last edge reads back its new value and x0 stays zero
  a_rs1_readback: assert property (@(posedge clk) disable iff (rst)
    ($past(we) && (rs1 == $past(rd))) |->
      (rs1_data == ((rs1 == '0) ? '0 : $past(rd_data))));

  a_rs2_readback: assert property (@(posedge clk) disable iff (rst)
    ($past(we) && (rs2 == $past(rd))) |->
      (rs2_data == ((rs2 == '0) ? '0 : $past(rd_data))));

endmodule

`default_nettype wire

// ==== rv_execute.sv ====
`default_nettype none

`include "rv_defs.svh"

module rv_execute import rv_pkg::*; (
  rv_decode_if.execute dec,
  input  word_t        pc,
  input  word_t        rs1_data,
  input  word_t        rs2_data,
  input  logic         exec_en,
  output logic         rf_we,
  output word_t        rf_wdata,
  output word_t        next_pc,
  output logic         halt_req
);

  word_t      op_b;
  logic [4:0] shamt;
  word_t      alu_res;
  logic       taken;
  word_t      pc_plus4;
  word_t      pc_plus_imm;
  word_t      jalr_sum;

  assign op_b  = dec.use_imm ? dec.imm : rs2_data;
  assign shamt = op_b[4:0]; // shifts use the low 5 bits only

  always_comb begin
    case (dec.alu_op)
      `RV_ALU_ADD:  alu_res = rs1_data + op_b;
      `RV_ALU_SUB:  alu_res = rs1_data - op_b;
      `RV_ALU_SLL:  alu_res = rs1_data << shamt;
      `RV_ALU_SLT:  alu_res = word_t'($signed(rs1_data) < $signed(op_b));
      `RV_ALU_SLTU: alu_res = word_t'(rs1_data < op_b);
      `RV_ALU_XOR:  alu_res = rs1_data ^ op_b;
      `RV_ALU_SRL:  alu_res = rs1_data >> shamt;
      `RV_ALU_SRA:  alu_res = word_t'($signed(rs1_data) >>> shamt);
      `RV_ALU_OR:   alu_res = rs1_data | op_b;
      `RV_ALU_AND:  alu_res = rs1_data & op_b;
      default:      alu_res = '0;
    endcase
  end

  // branch compare always uses rs2 and never the immediate
  always_comb begin
    case (dec.funct3)
      `RV_F3_BEQ:  taken = (rs1_data == rs2_data);
      `RV_F3_BNE:  taken = (rs1_data != rs2_data);
      `RV_F3_BLT:  taken = ($signed(rs1_data) < $signed(rs2_data));
      `RV_F3_BGE:  taken = ($signed(rs1_data) >= $signed(rs2_data));
      `RV_F3_BLTU: taken = (rs1_data < rs2_data);
      `RV_F3_BGEU: taken = (rs1_data >= rs2_data);
      default:     taken = 1'b0; // reserved encodings fall through
    endcase
  end

  assign pc_plus4    = pc + 32'd4;
  assign pc_plus_imm = pc + dec.imm;
  assign jalr_sum    = rs1_data + dec.imm;

  always_comb begin
    if (dec.is_jalr) begin
      next_pc = {jalr_sum[`RV_XLEN-1:1], 1'b0};
    end else if (dec.is_jal || (dec.is_branch && taken)) begin
      next_pc = pc_plus_imm;
    end else begin
      next_pc = pc_plus4;
    end
  end

  always_comb begin
    if (dec.is_jal || dec.is_jalr) begin
      rf_wdata = pc_plus4;     // link address
    end else if (dec.is_lui) begin
      rf_wdata = dec.imm;
    end else if (dec.is_auipc) begin
      rf_wdata = pc_plus_imm;
    end else begin
      rf_wdata = alu_res;
    end
  end

  assign rf_we    = dec.rf_we & exec_en;
  assign halt_req = dec.is_ecall;

  // pc and instruction are settled before the execute cycle begins
  // and register-writing classes other than jumps never redirect the pc
  a_seq_next_pc: assert property (@(posedge exec_en)
    (dec.rf_we && !dec.is_jal && !dec.is_jalr) |-> (next_pc == pc + 32'd4));

endmodule

`default_nettype wire

// ==== rv_fetch_ctrl.sv ====
`default_nettype none

module rv_fetch_ctrl import rv_pkg::*; (
  input  logic  clk,
  input  logic  rst,
  input  logic  fetch_ack,
  input  insn_t fetch_insn,
  input  word_t next_pc,
  input  logic  halt_req,
  output logic  fetch_req,
  output word_t fetch_pc,
  output insn_t insn,
  output word_t pc,
  output logic  exec_en,
  output logic  halted
);

  fetch_state_t state;
  fetch_state_t state_next;
  logic         ack_seen;

  // only accept ack while our own request is up
  assign ack_seen = fetch_req && fetch_ack;

  always_comb begin
    state_next = state;
    case (state)
      FETCH_REQ: begin
        if (ack_seen) begin
          state_next = FETCH_RELEASE;
        end
      end
      FETCH_RELEASE: begin
        if (!fetch_ack) begin
          state_next = EXECUTE;
        end
      end
      EXECUTE: state_next = halt_req ? HALTED : FETCH_REQ;
      default: state_next = HALTED; // left only through reset
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= FETCH_REQ;
      fetch_req <= 1'b0;
      pc        <= '0;
    end else begin
      state     <= state_next;
      fetch_req <= (state_next == FETCH_REQ); // drops on the ack edge
      if (exec_en) begin
        pc <= next_pc;
      end
    end
  end

  // instruction register
  always_ff @(posedge clk) begin
    if ((state == FETCH_REQ) && ack_seen) begin
      insn <= fetch_insn;
    end
  end

  assign fetch_pc = pc;   // pc only moves while req is low
  assign exec_en  = (state == EXECUTE);
  assign halted   = (state == HALTED);

  a_req_hold: assert property (@(posedge clk) disable iff (rst)
    (fetch_req && !fetch_ack) |=> (fetch_req && $stable(fetch_pc)));

endmodule

`default_nettype wire

// ==== rv_core.sv ====
`default_nettype none

module rv_core import rv_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  // instruction fetch, four-phase req/ack
  output logic      fetch_req,
  output word_t     fetch_pc,
  input  logic      fetch_ack,
  input  insn_t     fetch_insn,
  // retirement trace
  output logic      retire_valid,
  output word_t     retire_pc,
  output logic      retire_we,
  output reg_addr_t retire_rd,
  output word_t     retire_data,
  output logic      halted
);

  insn_t insn;
  word_t pc;
  logic  exec_en;
  word_t next_pc;
  logic  halt_req;
  word_t rs1_data;
  word_t rs2_data;
  logic  rf_we;
  word_t rf_wdata;

  rv_decode_if dec_if ();

  rv_fetch_ctrl u_fetch (
    .clk        (clk),
    .rst        (rst),
    .fetch_ack  (fetch_ack),
    .fetch_insn (fetch_insn),
    .next_pc    (next_pc),
    .halt_req   (halt_req),
    .fetch_req  (fetch_req),
    .fetch_pc   (fetch_pc),
    .insn       (insn),
    .pc         (pc),
    .exec_en    (exec_en),
    .halted     (halted)
  );

  rv_decoder u_decoder (
    .insn (insn),
    .dec  (dec_if.decoder)
  );

  rv_regfile u_regfile (
    .clk      (clk),
    .rst      (rst),
    .we       (rf_we),
    .rd       (dec_if.rd),
    .rd_data  (rf_wdata),
    .rs1      (dec_if.rs1),
    .rs2      (dec_if.rs2),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  rv_execute u_execute (
    .dec      (dec_if.execute),
    .pc       (pc),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .exec_en  (exec_en),
    .rf_we    (rf_we),
    .rf_wdata (rf_wdata),
    .next_pc  (next_pc),
    .halt_req (halt_req)
  );

  // trace is meaningful while retire_valid is high
  assign retire_valid = exec_en;
  assign retire_pc    = pc;
  assign retire_we    = rf_we;
  assign retire_rd    = dec_if.rd;
  assign retire_data  = rf_wdata;

endmodule

`default_nettype wire

// ==== tb_rv_model.svh ====
`ifndef TB_RV_MODEL_SVH
`define TB_RV_MODEL_SVH

// reference architectural state, entry 0 is never written
word_t       m_regs [0:`RV_NUM_REGS-1];
word_t       m_pc;
logic [31:0] lfsr_state;

// fibonacci lfsr, taps 32 22 2 1, one step per returned bit
function automatic logic [31:0] rand_bits(input int n);
  logic [31:0] val;
  logic        fb;
  val = '0;
  for (int i = 0; i < n; i++) begin
    fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
    lfsr_state = {lfsr_state[30:0], fb};
    val        = {val[30:0], fb};
  end
  return val;
endfunction

task automatic model_reset();
  foreach (m_regs[i]) begin
    m_regs[i] = '0;
  end
  m_pc = '0;
endtask

// integer ops as the isa defines them, alt picks sub / sra
function automatic word_t alu_ref(input logic [2:0] f3, input logic alt,
                                  input word_t a, input word_t b);
  case (f3)
    3'd0: return alt ? a - b : a + b;
    3'd1: return a << b[4:0];
    3'd2: return word_t'($signed(a) < $signed(b));
    3'd3: return word_t'(a < b);
    3'd4: return a ^ b;
    3'd5: return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
    3'd6: return a | b;
    default: return a & b;
  endcase
endfunction

// executes one instruction on the model state and reports the write-back
task automatic model_step(input insn_t insn, output logic we, output word_t wdata);
  word_t      a;
  word_t      b;
  word_t      imm_i;
  word_t      npc;
  logic [2:0] f3;
  logic       lt;
  a     = m_regs[insn[19:15]];
  b     = m_regs[insn[24:20]];
  f3    = insn[14:12];
  imm_i = {{20{insn[31]}}, insn[31:20]};
  npc   = m_pc + 4;
  we    = 1'b1;
  wdata = m_pc + 4; // link value for jal / jalr
  case (insn[6:0])
    `RV_OP_LUI:   wdata = {insn[31:12], 12'h000};
    `RV_OP_AUIPC: wdata = m_pc + {insn[31:12], 12'h000};
    `RV_OP_JAL:   npc = m_pc + {{12{insn[31]}}, insn[19:12], insn[20], insn[30:21], 1'b0};
    `RV_OP_JALR:  npc = (a + imm_i) & ~32'h1;
    `RV_OP_IMM:   wdata = alu_ref(f3, insn[30] && (f3 == 3'd5), a, imm_i);
    `RV_OP_REG:   wdata = alu_ref(f3, insn[30], a, b);
    `RV_OP_BRANCH: begin
      we = 1'b0;
      // bit 1 selects unsigned, bit 2 selects less-than, bit 0 inverts
      lt = f3[1] ? (a < b) : ($signed(a) < $signed(b));
      if ((f3[2] ? lt : (a == b)) ^ f3[0]) begin
        npc = m_pc + {{20{insn[31]}}, insn[7], insn[30:25], insn[11:8], 1'b0};
      end
    end
    default: we = 1'b0; // ecall and unknown opcodes
  endcase
  if (we && (insn[11:7] != 0)) begin
    m_regs[insn[11:7]] = wdata;
  end
  m_pc = npc;
endtask

`endif

// ==== tb_rv_core.sv ====
`default_nettype none

`include "rv_defs.svh"

module tb_rv_core import rv_pkg::*; ();

  localparam int          CLK_PERIOD    = 40;
  localparam int          RESET_CYCLES  = 4;
  localparam logic [31:0] LFSR_SEED     = 32'h534d_8274;
  localparam int          MAX_ACK_DELAY = 3;
  localparam int          HALT_CYCLES   = 20;
  localparam int          N_ALU         = 200;
  localparam int          N_X0          = 60;
  localparam int          N_CTRL        = 100;
  localparam int          N_UPPER       = 40;
  // 8 cycles per instruction at the longest ack delay, ecall counted, a few idle edges
  localparam int WATCHDOG_CYCLES =
    (N_ALU + N_X0 + N_CTRL + N_UPPER + 1) * 8 + RESET_CYCLES + HALT_CYCLES + 4;

  localparam int MODE_ALU   = 0;
  localparam int MODE_X0    = 1; // registers limited to x0..x3
  localparam int MODE_CTRL  = 2;
  localparam int MODE_UPPER = 3;
  localparam int MODE_ECALL = 4;

  logic      clk;
  logic      rst;
  logic      fetch_req;
  word_t     fetch_pc;
  logic      fetch_ack;
  insn_t     fetch_insn;
  logic      retire_valid;
  word_t     retire_pc;
  logic      retire_we;
  reg_addr_t retire_rd;
  word_t     retire_data;
  logic      halted;
  int        checks;
  int        errors;
  int        tests;
  int        failed_tests;
  int        mark;

  `include "tb_rv_model.svh"

  rv_core u_dut (.*);

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Timeout: the core stopped fetching or retiring before the tests finished");
    $display("Simulation FAILED");
    $finish;
  end

  task automatic check_word(input string what, input word_t exp, input word_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("Fail %s: expected %h, actual %h", what, exp, act);
    end
  endtask

  task automatic check_reg(input string what, input reg_addr_t exp, input reg_addr_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("Fail %s: expected x%0d, actual x%0d", what, exp, act);
    end
  endtask

  task automatic check_bit(input string what, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("Fail %s: expected %b, actual %b", what, exp, act);
    end
  endtask

  // class 0 op-imm, 1 op-reg, 2 branch, 3 jal, 4 jalr, 5 lui, 6 auipc, 7 unknown
  function automatic insn_t gen_insn(input int mode);
    int          rbits;
    logic [2:0]  cls;
    logic [2:0]  f3;
    logic [11:0] imm;
    logic [7:0]  hi;
    logic [12:0] boff;
    logic [20:0] joff;
    reg_addr_t   rd;
    reg_addr_t   rs1;
    reg_addr_t   rs2;
    if (mode == MODE_ECALL) begin
      return 32'h0000_0073;
    end
    rbits = (mode == MODE_X0) ? 2 : 5;
    rd    = reg_addr_t'(rand_bits(rbits));
    rs1   = reg_addr_t'(rand_bits(rbits));
    rs2   = reg_addr_t'(rand_bits(rbits));
    f3    = 3'(rand_bits(3));
    imm   = 12'(rand_bits(12));
    hi    = 8'(rand_bits(8));
    case (mode)
      MODE_CTRL:  cls = 3'(rand_bits(3));
      MODE_UPPER: cls = 3'd5 + 3'(rand_bits(1));
      default:    cls = 3'(rand_bits(1));
    endcase
    case (cls)
      3'd0: begin
        if (f3 == 3'd1) imm[11:5] = 7'b0;
        if (f3 == 3'd5) imm[11:5] = {1'b0, imm[10], 5'b0}; // srli or srai
        return {imm, rs1, f3, rd, `RV_OP_IMM};
      end
      3'd1: return {1'b0, imm[10] & ((f3 == 3'd0) || (f3 == 3'd5)), 5'b0,
                    rs2, rs1, f3, rd, `RV_OP_REG};
      3'd2: begin
        if (f3[2:1] == 2'b01) f3[2] = 1'b1; // 010 and 011 are no branches
        boff = {imm, 1'b0};
        return {boff[12], boff[10:5], rs2, rs1, f3, boff[4:1], boff[11], `RV_OP_BRANCH};
      end
      3'd3: begin
        joff = {hi, imm, 1'b0};
        return {joff[20], joff[10:1], joff[11], joff[19:12], rd, `RV_OP_JAL};
      end
      3'd4: return {imm, rs1, 3'b000, rd, `RV_OP_JALR};
      3'd5: return {hi, imm, rd, `RV_OP_LUI};
      3'd6: return {hi, imm, rd, `RV_OP_AUIPC};
      default: return {hi, imm, rd, 7'b0001011}; // custom-0, retires as a no-op
    endcase
  endfunction

  // answers one fetch, then checks the retirement against the model
  task automatic run_insn(input string test, input int mode);
    insn_t insn;
    word_t exp_pc;
    word_t exp_data;
    logic  exp_we;
    int    delay;
    do @(negedge clk); while (!fetch_req);
    check_word({test, " fetch_pc"}, m_pc, fetch_pc);
    exp_pc = m_pc;
    delay  = int'(rand_bits(2)) % (MAX_ACK_DELAY + 1);
    insn   = gen_insn(mode);
    repeat (delay) @(posedge clk);
    @(posedge clk);
    fetch_ack  <= 1'b1;
    fetch_insn <= insn;
    do @(negedge clk); while (fetch_req);
    @(posedge clk);
    fetch_ack <= 1'b0;
    do @(negedge clk); while (!retire_valid);
    model_step(insn, exp_we, exp_data);
    check_word({test, " retire_pc"}, exp_pc, retire_pc);
    check_bit({test, " retire_we"}, exp_we, retire_we);
    if (exp_we) begin
      check_reg({test, " retire_rd"}, reg_addr_t'(insn[11:7]), retire_rd);
      check_word({test, " retire_data"}, exp_data, retire_data);
    end
  endtask

  task automatic end_test(input string name, input int start_errors);
    tests++;
    if (errors == start_errors) begin
      $display("test %-8s ok", name);
    end else begin
      failed_tests++;
      $display("test %-8s %0d errors", name, errors - start_errors);
    end
  endtask

  task automatic run_test(input string name, input int mode, input int count);
    int start_errors;
    start_errors = errors;
    repeat (count) run_insn(name, mode);
    end_test(name, start_errors);
  endtask

  initial begin
    rst          = 1'b1;
    fetch_ack    = 1'b0;
    fetch_insn   = '0;
    checks       = 0;
    errors       = 0;
    tests        = 0;
    failed_tests = 0;
    lfsr_state   = LFSR_SEED;
    model_reset();
    repeat (RESET_CYCLES) @(posedge clk);
    rst <= 1'b0;

    mark = errors;
    @(negedge clk);
    check_bit("reset halted", 1'b0, halted);
    check_bit("reset retire_valid", 1'b0, retire_valid);
    do @(negedge clk); while (!fetch_req);
    check_word("reset fetch_pc", '0, fetch_pc);
    end_test("reset", mark);

    run_test("alu", MODE_ALU, N_ALU);
    run_test("x0", MODE_X0, N_X0);
    run_test("control", MODE_CTRL, N_CTRL);
    run_test("upper", MODE_UPPER, N_UPPER);

    // core must park after the ecall retires
    mark = errors;
    run_insn("halt", MODE_ECALL);
    repeat (HALT_CYCLES) begin
      @(negedge clk);
      check_bit("halt halted", 1'b1, halted);
      check_bit("halt fetch_req", 1'b0, fetch_req);
      check_bit("halt retire_valid", 1'b0, retire_valid);
    end
    end_test("halt", mark);

    $display("tests %0d, failing tests %0d, checks %0d, errors %0d",
             tests, failed_tests, checks, errors);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== rv_core.f ====
+incdir+.
rv_pkg.sv
rv_decode_if.sv
rv_decoder.sv
rv_regfile.sv
rv_execute.sv
rv_fetch_ctrl.sv
rv_core.sv
tb_rv_core.sv

// ==== Bender.yml ====
package:
  name: rv_core

sources:
  - include_dirs:
      - .
    files:
      - rv_pkg.sv
      - rv_decode_if.sv
      - rv_decoder.sv
      - rv_regfile.sv
      - rv_execute.sv
      - rv_fetch_ctrl.sv
      - rv_core.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_rv_core.sv
